// ==== logic/conv_pkg.sv ====
package conv_pkg;

	// Array geometry
	localparam int PIX_W   = 8;   // Pixel and weight width
	localparam int ROW_PIX = 8;   // Pixels in one row word
	localparam int KSIZE   = 3;   // Kernel side
	localparam int KTAPS   = KSIZE * KSIZE;
	localparam int PROD_W  = 2 * PIX_W;

	typedef logic [PIX_W-1:0] pix_t;

	// Pixel c sits at bits c*8 upward
	typedef logic [ROW_PIX*PIX_W-1:0] row_t;

	// Tap k at bits k*8, row-major over the 3x3 window
	typedef logic [KTAPS*PIX_W-1:0] kernel_t;

	// Product k at bits k*16, left unsummed
	typedef logic [KTAPS*PROD_W-1:0] patch_t;

	// Command encoding, the value 3 is treated as no command
	typedef enum logic [1:0] {
		CTRL_END   = 2'd0,
		CTRL_START = 2'd1,
		CTRL_HOLD  = 2'd2
	} ctrl_e;

	typedef enum logic [1:0] {
		ST_WAIT    = 2'd0,
		ST_COMPUTE = 2'd1,
		ST_FINISH  = 2'd2
	} state_e;

endpackage

// ==== logic/conv_ctrl.sv ====
module conv_ctrl (
	input  logic              clk,
	input  logic              rst,
	input  conv_pkg::ctrl_e   i_ctrl,
	output conv_pkg::state_e  o_state
);

	import conv_pkg::*;

	state_e state_next;

	always_comb begin
		state_next = o_state;   // No command keeps the state
		case (o_state)
			ST_WAIT: begin
				case (i_ctrl)
					CTRL_START: state_next = ST_COMPUTE;
					CTRL_END:   state_next = ST_FINISH;
					default:    state_next = ST_WAIT;
				endcase
			end
			ST_COMPUTE: begin
				case (i_ctrl)
					CTRL_HOLD: state_next = ST_WAIT;   // Back to loading rows and weights
					CTRL_END:  state_next = ST_FINISH;
					default:   state_next = ST_COMPUTE;
				endcase
			end
			ST_FINISH: begin
				state_next = ST_FINISH;   // Left only through reset
			end
			default: begin
				state_next = ST_WAIT;
			end
		endcase
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			o_state <= ST_WAIT;
		end else begin
			o_state <= state_next;
		end
	end

endmodule

// ==== logic/weight_store.sv ====
module weight_store (
	input  logic               clk,
	input  logic               rst,
	input  conv_pkg::state_e   i_state,
	input  logic               i_row_valid,
	input  logic               i_wgt_valid,
	input  conv_pkg::row_t     i_wgt,
	output conv_pkg::kernel_t  o_kernel,
	output logic               o_wgt_loaded
);

	import conv_pkg::*;

	localparam int LO_W = ROW_PIX * PIX_W;   // Taps 0 to 7 from the first beat

	logic [1:0] beat_cnt;
	logic [1:0] cnt_eff;
	logic       was_compute;
	logic       restart;
	logic       accept;

	// A row on the same edge wins over a weight beat
	assign accept = (i_state == ST_WAIT) && i_wgt_valid && !i_row_valid;

	// COMPUTE only exits to WAIT through HOLD, so this marks the first cycle after it
	assign restart = was_compute && (i_state == ST_WAIT);
	assign cnt_eff = restart ? 2'd0 : beat_cnt;   // Counter reads as cleared from that edge on

	assign o_wgt_loaded = (cnt_eff == 2'd2);

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			beat_cnt    <= 2'd0;
			was_compute <= 1'b0;
			o_kernel    <= '0;
		end else begin
			was_compute <= (i_state == ST_COMPUTE);
			beat_cnt    <= cnt_eff;
			if (accept) begin
				case (cnt_eff)
					2'd0: begin
						o_kernel[LO_W-1:0] <= i_wgt;
						beat_cnt           <= 2'd1;
					end
					2'd1: begin
						o_kernel[KTAPS*PIX_W-1 -: PIX_W] <= i_wgt[PIX_W-1:0];   // Tap 8 from byte 0
						beat_cnt                         <= 2'd2;
					end
					default: begin
						beat_cnt <= cnt_eff;   // Extra beats dropped until the next HOLD
					end
				endcase
			end
		end
	end

endmodule

// ==== logic/row_window.sv ====
module row_window (
	input  logic              clk,
	input  logic              rst,
	input  conv_pkg::state_e  i_state,
	input  logic              i_row_valid,
	input  conv_pkg::row_t    i_row,
	output conv_pkg::row_t    o_row_a,
	output conv_pkg::row_t    o_row_b,
	output conv_pkg::row_t    o_row_c
);

	import conv_pkg::*;

	logic shift_en;

	// Rows are frozen outside WAIT so a running window stays stable
	assign shift_en = (i_state == ST_WAIT) && i_row_valid;

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			o_row_a <= '0;
			o_row_b <= '0;
			o_row_c <= '0;
		end else if (shift_en) begin
			o_row_a <= o_row_b;   // Oldest row drops out
			o_row_b <= o_row_c;
			o_row_c <= i_row;     // Newest row
		end
	end

endmodule

// ==== logic/window_lane.sv ====
module window_lane #(
	parameter int LANE = 0   // Column offset of the patch
) (
	input  logic               clk,
	input  logic               rst,
	input  logic               i_compute,
	input  conv_pkg::row_t     i_row_a,
	input  conv_pkg::row_t     i_row_b,
	input  conv_pkg::row_t     i_row_c,
	input  conv_pkg::kernel_t  i_kernel,
	output conv_pkg::patch_t   o_patch,
	output logic               o_valid
);

	import conv_pkg::*;

	row_t   rows [KSIZE];
	pix_t   pix  [KTAPS];
	patch_t prod_d;

	assign rows[0] = i_row_a;
	assign rows[1] = i_row_b;
	assign rows[2] = i_row_c;

	// Tap k reads row k/3, column wrapped modulo the row width
	always_comb begin
		for (int k = 0; k < KTAPS; k++) begin
			pix[k] = rows[k / KSIZE][((LANE + k % KSIZE) % ROW_PIX) * PIX_W +: PIX_W];
		end
	end

	always_comb begin
		for (int k = 0; k < KTAPS; k++) begin
			prod_d[k*PROD_W +: PROD_W] = PROD_W'(pix[k]) * PROD_W'(i_kernel[k*PIX_W +: PIX_W]);
		end
	end

	// Products held between compute cycles
	always_ff @(posedge clk) begin
		if (i_compute) begin
			o_patch <= prod_d;
		end
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			o_valid <= 1'b0;
		end else begin
			o_valid <= i_compute;   // One cycle behind the strobe
		end
	end

endmodule

// ==== logic/conv_array.sv ====
module conv_array #(
	parameter int NUM_LANES = 8   // Up to ROW_PIX
) (
	input  logic                              clk,
	input  logic                              rst,
	input  conv_pkg::ctrl_e                   i_ctrl,
	input  logic                              i_row_valid,
	input  conv_pkg::row_t                    i_row,
	input  logic                              i_wgt_valid,
	input  conv_pkg::row_t                    i_wgt,
	output conv_pkg::patch_t [NUM_LANES-1:0]  o_products,
	output logic                              o_res_valid,
	output logic                              o_finish,
	output logic                              o_wgt_loaded
);

	import conv_pkg::*;

	state_e  state;
	kernel_t kernel;
	row_t    row_a;
	row_t    row_b;
	row_t    row_c;
	logic    compute;

	assign compute  = (state == ST_COMPUTE);
	assign o_finish = (state == ST_FINISH);

	conv_ctrl ctrl_i (
		.clk     (clk),
		.rst     (rst),
		.i_ctrl  (i_ctrl),
		.o_state (state)
	);

	weight_store wgt_i (
		.clk          (clk),
		.rst          (rst),
		.i_state      (state),
		.i_row_valid  (i_row_valid),
		.i_wgt_valid  (i_wgt_valid),
		.i_wgt        (i_wgt),
		.o_kernel     (kernel),
		.o_wgt_loaded (o_wgt_loaded)
	);

	row_window rows_i (
		.clk         (clk),
		.rst         (rst),
		.i_state     (state),
		.i_row_valid (i_row_valid),
		.i_row       (i_row),
		.o_row_a     (row_a),
		.o_row_b     (row_b),
		.o_row_c     (row_c)
	);

	// One lane per column offset, all sharing rows and kernel
	for (genvar n = 0; n < NUM_LANES; n++) begin : g_lane
		if (n == 0) begin : g_lead
			// Lane 0 supplies the array's result valid
			window_lane #(
				.LANE (n)
			) lane_i (
				.clk       (clk),
				.rst       (rst),
				.i_compute (compute),
				.i_row_a   (row_a),
				.i_row_b   (row_b),
				.i_row_c   (row_c),
				.i_kernel  (kernel),
				.o_patch   (o_products[n]),
				.o_valid   (o_res_valid)
			);
		end else begin : g_rest
			window_lane #(
				.LANE (n)
			) lane_i (
				.clk       (clk),
				.rst       (rst),
				.i_compute (compute),
				.i_row_a   (row_a),
				.i_row_b   (row_b),
				.i_row_c   (row_c),
				.i_kernel  (kernel),
				.o_patch   (o_products[n]),
				.o_valid   ()   // Same timing as lane 0
			);
		end
	end

endmodule

// ==== dv/conv_asserts.sv ====
module conv_asserts #(
	parameter int NUM_LANES = 8
) (
	input logic                              clk,
	input logic                              rst,
	input conv_pkg::ctrl_e                   i_ctrl,
	input logic                              i_row_valid,
	input conv_pkg::row_t                    i_row,
	input logic                              i_wgt_valid,
	input conv_pkg::row_t                    i_wgt,
	input conv_pkg::patch_t [NUM_LANES-1:0]  o_products,
	input logic                              o_res_valid,
	input logic                              o_finish,
	input logic                              o_wgt_loaded
);

	import conv_pkg::*;

	state_e                 m_state;        // Command machine as seen from the ports
	row_t                   m_row_a;        // Oldest row
	row_t                   m_row_b;
	row_t                   m_row_c;        // Newest row
	kernel_t                m_kernel;
	int                     m_beats;
	logic                   exp_valid;
	patch_t [NUM_LANES-1:0] exp_products;
	int                     fail_cnt = 0;   // Read by the testbench at the end

	// 3x3 patch at column offset lane, columns wrap around the row word
	function automatic patch_t expect_patch(input int lane, input row_t ra, input row_t rb,
			input row_t rc, input kernel_t kern);
		row_t   win [KSIZE];
		patch_t res;
		int     col;
		pix_t   px;
		pix_t   wt;
		win[0] = ra;
		win[1] = rb;
		win[2] = rc;
		res = '0;
		for (int k = 0; k < KTAPS; k++) begin
			col = (lane + (k % KSIZE)) % ROW_PIX;
			px  = win[k / KSIZE][col*PIX_W +: PIX_W];
			wt  = kern[k*PIX_W +: PIX_W];
			res[k*PROD_W +: PROD_W] = PROD_W'(px) * PROD_W'(wt);
		end
		return res;
	endfunction

	always @(posedge clk or negedge rst) begin
		if (!rst) begin
			m_state      <= ST_WAIT;
			m_row_a      <= '0;
			m_row_b      <= '0;
			m_row_c      <= '0;
			m_kernel     <= '0;
			m_beats      <= 0;
			exp_valid    <= 1'b0;
			exp_products <= '0;
		end else begin
			if (m_state == ST_WAIT && i_row_valid) begin
				m_row_a <= m_row_b;
				m_row_b <= m_row_c;
				m_row_c <= i_row;
			end else if (m_state == ST_WAIT && i_wgt_valid) begin
				if (m_beats == 0) begin
					m_kernel[0 +: ROW_PIX*PIX_W] <= i_wgt;   // Taps 0 to 7
					m_beats                      <= 1;
				end else if (m_beats == 1) begin
					m_kernel[8*PIX_W +: PIX_W] <= i_wgt[PIX_W-1:0];
					m_beats                    <= 2;
				end
			end
			exp_valid <= (m_state == ST_COMPUTE);
			if (m_state == ST_COMPUTE) begin
				for (int n = 0; n < NUM_LANES; n++) begin
					exp_products[n] <= expect_patch(n, m_row_a, m_row_b, m_row_c, m_kernel);
				end
			end
			case (m_state)
				ST_WAIT: begin
					if (i_ctrl == CTRL_START) begin
						m_state <= ST_COMPUTE;
					end else if (i_ctrl == CTRL_END) begin
						m_state <= ST_FINISH;
					end
				end
				ST_COMPUTE: begin
					if (i_ctrl == CTRL_HOLD) begin
						m_state <= ST_WAIT;
						m_beats <= 0;   // Kernel may be reloaded after HOLD
					end else if (i_ctrl == CTRL_END) begin
						m_state <= ST_FINISH;
					end
				end
				default: begin
				end
			endcase
		end
	end

	a_reset_quiet: assert property (@(posedge clk) !rst |-> !o_res_valid && !o_finish && !o_wgt_loaded)
		else begin
			fail_cnt++;
			$error("Outputs were not all low while reset was applied");
		end

	a_res_valid: assert property (@(posedge clk) disable iff (!rst) o_res_valid == exp_valid)
		else begin
			fail_cnt++;
			$error("[ERROR] res_valid_timing: expected %0b actual %0b",
				$sampled(exp_valid), $sampled(o_res_valid));
		end

	a_finish: assert property (@(posedge clk) disable iff (!rst) o_finish == (m_state == ST_FINISH))
		else begin
			fail_cnt++;
			$error("[ERROR] finish_flag: expected %0b actual %0b",
				$sampled(m_state == ST_FINISH), $sampled(o_finish));
		end

	a_wgt_loaded: assert property (@(posedge clk) disable iff (!rst) o_wgt_loaded == (m_beats == 2))
		else begin
			fail_cnt++;
			$error("[ERROR] wgt_loaded: expected %0b actual %0b",
				$sampled(m_beats == 2), $sampled(o_wgt_loaded));
		end

	// END is absorbing and silences the results
	a_finish_sticky: assert property (@(posedge clk) disable iff (!rst)
			o_finish |=> o_finish && !o_res_valid)
		else begin
			fail_cnt++;
			$error("Finish flag dropped or a result appeared after END");
		end

	for (genvar n = 0; n < NUM_LANES; n++) begin : g_lane_chk
		a_products: assert property (@(posedge clk) disable iff (!rst)
				exp_valid |-> o_products[n] == exp_products[n])
			else begin
				fail_cnt++;
				$error("[ERROR] products_lane%0d: expected %h actual %h", n,
					$sampled(exp_products[n]), $sampled(o_products[n]));
			end
	end

endmodule

// ==== dv/conv_tb.sv ====
module conv_tb;

	import conv_pkg::*;

	localparam int         NUM_LANES   = 8;
	localparam int         PHASES      = 7;    // Reset, load, compute, new rows, new kernel, random, end
	localparam int         PHASE_LEN   = 40;   // Cycle budget per phase
	localparam int         CYCLE_LIMIT = PHASES * PHASE_LEN;
	localparam logic [1:0] NO_CMD      = 2'd3;

	logic                   clk;
	logic                   rst;
	ctrl_e                  ctrl;
	logic                   row_valid;
	row_t                   row;
	logic                   wgt_valid;
	row_t                   wgt;
	patch_t [NUM_LANES-1:0] products;
	logic                   res_valid;
	logic                   finish;
	logic                   wgt_loaded;

	logic [31:0] lcg_state;
	int          cycles = 0;
	int          errs;

	conv_array #(
		.NUM_LANES (NUM_LANES)
	) dut_i (
		.clk          (clk),
		.rst          (rst),
		.i_ctrl       (ctrl),
		.i_row_valid  (row_valid),
		.i_row        (row),
		.i_wgt_valid  (wgt_valid),
		.i_wgt        (wgt),
		.o_products   (products),
		.o_res_valid  (res_valid),
		.o_finish     (finish),
		.o_wgt_loaded (wgt_loaded)
	);

	bind conv_array conv_asserts #(
		.NUM_LANES (NUM_LANES)
	) asserts_i (
		.clk          (clk),
		.rst          (rst),
		.i_ctrl       (i_ctrl),
		.i_row_valid  (i_row_valid),
		.i_row        (i_row),
		.i_wgt_valid  (i_wgt_valid),
		.i_wgt        (i_wgt),
		.o_products   (o_products),
		.o_res_valid  (o_res_valid),
		.o_finish     (o_finish),
		.o_wgt_loaded (o_wgt_loaded)
	);

	always #20 clk = ~clk;

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("Timeout: stimulus did not complete within %0d cycles", CYCLE_LIMIT);
			$display("Something failed");
			$finish;
		end
	end

	function automatic logic [31:0] next_random();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic row_t random_word();
		logic [31:0] lo;
		logic [31:0] hi;
		lo = next_random();
		hi = next_random();
		return {hi, lo};
	endfunction

	// All inputs set together, one edge per call
	task automatic drive(input logic [1:0] cmd, input logic rv, input row_t r,
			input logic wv, input row_t w);
		@(posedge clk);
		ctrl      <= ctrl_e'(cmd);
		row_valid <= rv;
		row       <= r;
		wgt_valid <= wv;
		wgt       <= w;
	endtask

	task automatic idle(input int n);
		repeat (n) drive(NO_CMD, 1'b0, '0, 1'b0, '0);
	endtask

	task automatic send_row();
		drive(NO_CMD, 1'b1, random_word(), 1'b0, '0);
	endtask

	task automatic send_weight_beat();
		drive(NO_CMD, 1'b0, '0, 1'b1, random_word());
	endtask

	// START held for n cycles, then HOLD
	task automatic run_compute(input int n, input logic offer_rows);
		repeat (n) drive(CTRL_START, offer_rows, random_word(), 1'b0, '0);
		drive(CTRL_HOLD, 1'b0, '0, 1'b0, '0);
	endtask

	task automatic scramble_inputs(input int n);
		logic [31:0] r;
		repeat (n) begin
			r = next_random();
			drive(r[17:16], r[20], random_word(), r[21], random_word());
		end
	endtask

	initial begin
		logic [31:0] r;
		lcg_state = 32'hd723;
		clk       = 1'b0;
		rst       = 1'b0;
		ctrl      = ctrl_e'(NO_CMD);
		row_valid = 1'b0;
		row       = '0;
		wgt_valid = 1'b0;
		wgt       = '0;
		repeat (4) @(posedge clk);
		rst <= 1'b1;
		idle(2);

		repeat (2) send_row();
		send_weight_beat();
		drive(NO_CMD, 1'b1, random_word(), 1'b1, random_word());   // Row wins, beat dropped
		send_weight_beat();
		send_weight_beat();   // Extra beat, kernel must stay
		idle(2);

		run_compute(4, 1'b1);   // Rows offered in COMPUTE are ignored
		idle(1);

		repeat (2) send_row();
		run_compute(3, 1'b0);
		idle(1);

		// Kernel reload after HOLD
		send_weight_beat();
		send_weight_beat();
		run_compute(3, 1'b1);
		idle(1);

		for (int i = 0; i < 4; i++) begin
			r = next_random();
			repeat (r[1:0] + 1) send_row();
			if (r[4]) begin
				send_weight_beat();
				send_weight_beat();
			end
			run_compute(r[9:8] + 1, r[12]);
			idle(1);
		end

		// END from COMPUTE, then anything goes
		drive(CTRL_START, 1'b0, '0, 1'b0, '0);
		drive(CTRL_START, 1'b0, '0, 1'b0, '0);
		drive(CTRL_END, 1'b0, '0, 1'b0, '0);
		scramble_inputs(20);
		idle(3);

		errs = dut_i.asserts_i.fail_cnt;
		$display("Run closed after %0d cycles with %0d assertion failures", cycles, errs);
		if (errs == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

// ==== tb.f ====
logic/conv_pkg.sv
logic/conv_ctrl.sv
logic/weight_store.sv
logic/row_window.sv
logic/window_lane.sv
logic/conv_array.sv
dv/conv_asserts.sv
dv/conv_tb.sv
